/* test/axi_stim.txt */
# op: W write, R read, P mem and fetch read together; master: M data port, I fetch port
# op master addr len burst(I incr, F fixed) data strb resp(O okay, S slverr); P: data = fetch addr
W M 00000000 3 I 1000000000000000 ff O
R M 00000000 3 I 0 ff O
W M 00000100 7 I 2000000000000000 ff O
R M 00000100 7 I 0 ff O
R I 00000100 7 I 0 ff O
R I 00000008 1 I 0 ff O
W M 00000200 1 I 3000000000000000 ff O
P M 00000200 1 I 00000000 ff O
P M 00000100 3 I 00000118 ff O
P M 00000008 2 I 00000110 ff O
W M 00000300 3 F 4000000000000000 ff O
R M 00000300 0 I 0 ff O
R I 00000300 2 F 0 ff O
W M 00000000 0 I aaaaaaaaaaaaaaaa 0f O
W M 00000008 1 I bbbbbbbb00000000 f0 O
R M 00000000 3 I 0 ff O
W M 00000300 1 F 0123456789abcdef 3c O
R M 00000300 0 I 0 ff O
W M 00000400 15 I 5000000000000000 ff O
R M 00000400 15 I 0 ff O
R I 00000440 7 I 0 ff O
P M 00000440 3 I 00000400 ff O
W M 000007f0 3 I 6000000000000000 ff S
R M 000007f0 3 I 0 ff S
R I 000007f8 1 I 0 ff S
W M 00000800 1 I 7000000000000000 ff S
R M 00000800 1 I 0 ff S
R M 00000900 2 F 0 ff S
R M 000007f0 1 I 0 ff O
R M 00000000 1 I 0 ff O
W M 000007f8 0 F 8000000000000000 ff O
R I 000007f0 1 I 0 ff O

/* vlog.f */
hdl/axi_pkg.sv
hdl/soc_pkg.sv
hdl/axi_interconnect.sv
hdl/axi_sram_slave.sv
hdl/axi_mem_subsys.sv
test/tb_axi_mem_subsys.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_axi_mem_subsys
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

/* test/tb_axi_mem_subsys.sv */
// testbench for the AXI memory subsystem
// drives the data and fetch masters from a stimulus file
// reference memory model, random ready stalls, watchdog
module tb_axi_mem_subsys;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int depth           = 256;
	localparam int cycle_ns        = 10;
	localparam int cycles_per_line = 200;

	typedef struct packed {
		logic [7:0]         op;
		logic [7:0]         mst;
		logic [31:0]        addr;
		logic [7:0]         len;
		logic               fixed;
		logic [63:0]        data;
		logic [7:0]         strb;
		axi_pkg::axi_resp_e resp;
	} stim_t;

	logic clk = 1'b0;
	logic rst_n;
	axi_pkg::axi_ax_t mem_aw;
	logic             mem_aw_valid;
	logic             mem_aw_ready;
	axi_pkg::axi_w_t  mem_w;
	logic             mem_w_valid;
	logic             mem_w_ready;
	axi_pkg::axi_b_t  mem_b;
	logic             mem_b_valid;
	logic             mem_b_ready;
	axi_pkg::axi_ax_t mem_ar;
	logic             mem_ar_valid;
	logic             mem_ar_ready;
	axi_pkg::axi_r_t  mem_r;
	logic             mem_r_valid;
	logic             mem_r_ready;
	axi_pkg::axi_ax_t if_ar;
	logic             if_ar_valid;
	logic             if_ar_ready;
	axi_pkg::axi_r_t  if_r;
	logic             if_r_valid;
	logic             if_r_ready;

	logic [63:0] model [depth];
	logic [31:0] rng = 32'h877c_8b9a;
	int errors = 0;
	int checks = 0;
	int cur_line = 0;
	stim_t stim_q[$];

	axi_mem_subsys #(
		.DEPTH (depth)
	) u_axi_mem_subsys (.*);

	always #(cycle_ns / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// word address of beat k
	function automatic logic [31:0] beat_word(input logic [31:0] addr, input logic fixed,
			input int k);
		return (addr >> 3) + (fixed ? 32'd0 : 32'(k));
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error @ %0t ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	// ready high about three cycles in four
	task automatic random_ready(output logic rdy);
		rng = xorshift32(rng);
		rdy = (rng[1:0] != 2'b00);
	endtask

	task automatic load_stimulus(output logic ok);
		int fd;
		int n;
		int len;
		string line;
		logic [7:0] op;
		logic [7:0] mst;
		logic [7:0] burst;
		logic [7:0] resp;
		logic [7:0] strb;
		logic [31:0] addr;
		logic [63:0] data;
		stim_t s;
		fd = $fopen("test/axi_stim.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%c %c %h %d %c %h %h %c",
					op, mst, addr, len, burst, data, strb, resp);
				if (line.len() > 1 && line[0] != "#" && n == 8) begin
					s.op    = op;
					s.mst   = mst;
					s.addr  = addr;
					s.len   = 8'(len);
					s.fixed = (burst == "F");
					s.data  = data;
					s.strb  = strb;
					s.resp  = (resp == "S") ? axi_pkg::SLVERR : axi_pkg::OKAY;
					stim_q.push_back(s);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic write_burst(input stim_t s);
		logic [31:0] word;
		logic fire;
		mem_aw.id    = 4'h2;
		mem_aw.addr  = s.addr;
		mem_aw.len   = s.len;
		mem_aw.size  = 3'd3;
		mem_aw.burst = s.fixed ? axi_pkg::FIXED : axi_pkg::INCR;
		mem_aw_valid = 1'b1;
		do @(negedge clk); while (!mem_aw_ready);
		@(posedge clk);
		#1 mem_aw_valid = 1'b0;
		for (int k = 0; k <= int'(s.len); k++) begin
			mem_w.data  = s.data + 64'(k);
			mem_w.strb  = s.strb;
			mem_w.last  = (k == int'(s.len));
			mem_w_valid = 1'b1;
			do @(negedge clk); while (!mem_w_ready);
			word = beat_word(s.addr, s.fixed, k);
			if (word < depth) begin
				for (int i = 0; i < 8; i++) begin
					if (s.strb[i]) begin
						model[word[7:0]][8*i +: 8] = mem_w.data[8*i +: 8];
					end
				end
			end
			@(posedge clk);
			#1;
		end
		mem_w_valid = 1'b0;
		fire = 1'b0;
		while (!fire) begin
			random_ready(mem_b_ready);
			@(negedge clk);
			fire = mem_b_valid & mem_b_ready;
			if (fire) begin
				check_value("b resp", 64'(mem_b.resp), 64'(s.resp));
				check_value("b id", 64'(mem_b.id), 64'(4'h2));
			end
			@(posedge clk);
			#1;
		end
		mem_b_ready = 1'b0;
	endtask

	task automatic read_burst(input logic use_if, input logic [31:0] addr, input stim_t s,
			output time t_first);
		axi_pkg::axi_ax_t req;
		axi_pkg::axi_r_t beat;
		logic [31:0] word;
		logic fire;
		logic other_valid;
		int k;
		req.id    = use_if ? 4'h1 : 4'h2;
		req.addr  = addr;
		req.len   = s.len;
		req.size  = 3'd3;
		req.burst = s.fixed ? axi_pkg::FIXED : axi_pkg::INCR;
		t_first = 0;
		if (use_if) begin
			if_ar       = req;
			if_ar_valid = 1'b1;
		end else begin
			mem_ar       = req;
			mem_ar_valid = 1'b1;
		end
		do @(negedge clk); while (!(use_if ? if_ar_ready : mem_ar_ready));
		@(posedge clk);
		#1;
		if (use_if) if_ar_valid = 1'b0;
		else mem_ar_valid = 1'b0;
		k = 0;
		while (k <= int'(s.len)) begin
			if (use_if) random_ready(if_r_ready);
			else random_ready(mem_r_ready);
			@(negedge clk);
			beat = use_if ? if_r : mem_r;
			fire = use_if ? (if_r_valid & if_r_ready) : (mem_r_valid & mem_r_ready);
			other_valid = use_if ? mem_r_valid : if_r_valid;
			check_value("r_valid seen by the other master", 64'(other_valid), 64'(0));
			if (fire) begin
				// beats past the end of the SRAM read as zero
				word = beat_word(addr, s.fixed, k);
				check_value("r data", beat.data, (word < depth) ? model[word[7:0]] : 64'(0));
				check_value("r resp", 64'(beat.resp), 64'(s.resp));
				check_value("r last", 64'(beat.last), 64'(k == int'(s.len)));
				check_value("r id", 64'(beat.id), 64'(req.id));
				if (k == 0) t_first = $time;
				k++;
			end
			@(posedge clk);
			#1;
		end
		if (use_if) if_r_ready = 1'b0;
		else mem_r_ready = 1'b0;
	endtask

	initial begin
		stim_t s;
		time t_mem;
		time t_if;
		longint limit_ns;
		logic ok;
		rst_n        = 1'b0;
		mem_aw       = '0;
		mem_aw_valid = 1'b0;
		mem_w        = '0;
		mem_w_valid  = 1'b0;
		mem_b_ready  = 1'b0;
		mem_ar       = '0;
		mem_ar_valid = 1'b0;
		mem_r_ready  = 1'b0;
		if_ar        = '0;
		if_ar_valid  = 1'b0;
		if_r_ready   = 1'b0;
		foreach (model[i]) model[i] = '0;
		load_stimulus(ok);
		if (!ok) begin
			$display("cannot open test/axi_stim.txt, there is no stimulus to run");
			$display("Regression failed");
			$finish;
		end else begin
			limit_ns = longint'(16 + stim_q.size() * cycles_per_line) * cycle_ns;
			fork
				begin
					#(limit_ns);
					$display("timeout: stimulus line %0d still running after %0d ns",
						cur_line, limit_ns);
					$display("Regression failed");
					$finish;
				end
			join_none
			repeat (16) @(posedge clk);
			#1 rst_n = 1'b1;
			foreach (stim_q[i]) begin
				cur_line = i + 1;
				s = stim_q[i];
				case (s.op)
					"W": write_burst(s);
					"R": read_burst(s.mst == "I", s.addr, s, t_mem);
					"P": begin
						// both requests go out in the same cycle
						fork
							read_burst(1'b0, s.addr, s, t_mem);
							read_burst(1'b1, s.data[31:0], s, t_if);
						join
						check_value("mem data ahead of fetch data", 64'(t_mem < t_if), 64'(1));
					end
					default: begin
						errors++;
						$display("stimulus line %0d has an unknown operation", i + 1);
					end
				endcase
			end
			$display("checks %0d, errors %0d", checks, errors);
			if (errors == 0) begin
				$display("Regression passed");
			end else begin
				$display("Regression failed");
			end
			$finish;
		end
	end

endmodule

/* hdl/axi_mem_subsys.sv */
// memory subsystem top
// interconnect for the fetch and data ports plus on-chip SRAM
module axi_mem_subsys #(
	parameter int DEPTH = 1024
) (
	input  logic             clk,
	input  logic             rst_n,
	input  axi_pkg::axi_ax_t mem_aw,
	input  logic             mem_aw_valid,
	output logic             mem_aw_ready,
	input  axi_pkg::axi_w_t  mem_w,
	input  logic             mem_w_valid,
	output logic             mem_w_ready,
	output axi_pkg::axi_b_t  mem_b,
	output logic             mem_b_valid,
	input  logic             mem_b_ready,
	input  axi_pkg::axi_ax_t mem_ar,
	input  logic             mem_ar_valid,
	output logic             mem_ar_ready,
	output axi_pkg::axi_r_t  mem_r,
	output logic             mem_r_valid,
	input  logic             mem_r_ready,
	input  axi_pkg::axi_ax_t if_ar,
	input  logic             if_ar_valid,
	output logic             if_ar_ready,
	output axi_pkg::axi_r_t  if_r,
	output logic             if_r_valid,
	input  logic             if_r_ready
);

	// shared slave port
	axi_pkg::axi_ax_t axi_aw;
	axi_pkg::axi_w_t  axi_w;
	axi_pkg::axi_b_t  axi_b;
	axi_pkg::axi_ax_t axi_ar;
	axi_pkg::axi_r_t  axi_r;
	logic axi_aw_valid;
	logic axi_aw_ready;
	logic axi_w_valid;
	logic axi_w_ready;
	logic axi_b_valid;
	logic axi_b_ready;
	logic axi_ar_valid;
	logic axi_ar_ready;
	logic axi_r_valid;
	logic axi_r_ready;

	axi_interconnect u_interconnect (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_aw       (mem_aw),
		.mem_aw_valid (mem_aw_valid),
		.mem_aw_ready (mem_aw_ready),
		.mem_w        (mem_w),
		.mem_w_valid  (mem_w_valid),
		.mem_w_ready  (mem_w_ready),
		.mem_b        (mem_b),
		.mem_b_valid  (mem_b_valid),
		.mem_b_ready  (mem_b_ready),
		.mem_ar       (mem_ar),
		.mem_ar_valid (mem_ar_valid),
		.mem_ar_ready (mem_ar_ready),
		.mem_r        (mem_r),
		.mem_r_valid  (mem_r_valid),
		.mem_r_ready  (mem_r_ready),
		.if_ar        (if_ar),
		.if_ar_valid  (if_ar_valid),
		.if_ar_ready  (if_ar_ready),
		.if_r         (if_r),
		.if_r_valid   (if_r_valid),
		.if_r_ready   (if_r_ready),
		.axi_aw       (axi_aw),
		.axi_aw_valid (axi_aw_valid),
		.axi_aw_ready (axi_aw_ready),
		.axi_w        (axi_w),
		.axi_w_valid  (axi_w_valid),
		.axi_w_ready  (axi_w_ready),
		.axi_b        (axi_b),
		.axi_b_valid  (axi_b_valid),
		.axi_b_ready  (axi_b_ready),
		.axi_ar       (axi_ar),
		.axi_ar_valid (axi_ar_valid),
		.axi_ar_ready (axi_ar_ready),
		.axi_r        (axi_r),
		.axi_r_valid  (axi_r_valid),
		.axi_r_ready  (axi_r_ready)
	);

	axi_sram_slave #(
		.DEPTH (DEPTH)
	) u_sram (
		.clk      (clk),
		.rst_n    (rst_n),
		.aw       (axi_aw),
		.aw_valid (axi_aw_valid),
		.aw_ready (axi_aw_ready),
		.w        (axi_w),
		.w_valid  (axi_w_valid),
		.w_ready  (axi_w_ready),
		.b        (axi_b),
		.b_valid  (axi_b_valid),
		.b_ready  (axi_b_ready),
		.ar       (axi_ar),
		.ar_valid (axi_ar_valid),
		.ar_ready (axi_ar_ready),
		.r        (axi_r),
		.r_valid  (axi_r_valid),
		.r_ready  (axi_r_ready)
	);

endmodule

/* hdl/axi_sram_slave.sv */
// AXI slave in front of a word-addressed SRAM
// independent write and read engines, INCR and FIXED bursts
// byte strobes, SLVERR for beats beyond DEPTH
module axi_sram_slave #(
	parameter int DEPTH = 1024
) (
	input  logic             clk,
	input  logic             rst_n,
	input  axi_pkg::axi_ax_t aw,
	input  logic             aw_valid,
	output logic             aw_ready,
	input  axi_pkg::axi_w_t  w,
	input  logic             w_valid,
	output logic             w_ready,
	output axi_pkg::axi_b_t  b,
	output logic             b_valid,
	input  logic             b_ready,
	input  axi_pkg::axi_ax_t ar,
	input  logic             ar_valid,
	output logic             ar_ready,
	output axi_pkg::axi_r_t  r,
	output logic             r_valid,
	input  logic             r_ready
);

	localparam int idx_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int off_w = $clog2(axi_pkg::strb_w);

	logic [axi_pkg::data_w-1:0] mem [DEPTH];

	soc_pkg::sram_state_e       wr_state;
	logic [axi_pkg::addr_w-1:0] wr_addr;
	logic [7:0]                 wr_left;
	logic [axi_pkg::id_w-1:0]   wr_id;
	logic                       wr_fixed;
	logic                       wr_err;

	logic                       rd_active;
	logic [axi_pkg::addr_w-1:0] rd_addr;
	logic [axi_pkg::addr_w-1:0] rd_next;
	logic [axi_pkg::addr_w-1:0] rd_src;
	logic [axi_pkg::data_w-1:0] rd_word;
	logic [axi_pkg::data_w-1:0] rd_data;
	logic [7:0]                 rd_left;
	logic [axi_pkg::id_w-1:0]   rd_id;
	logic                       rd_fixed;
	logic                       rd_err;

	logic aw_fire;
	logic w_fire;
	logic ar_fire;
	logic r_fire;
	logic r_last;
	logic [axi_pkg::addr_w-1:0] aw_word;
	logic [axi_pkg::addr_w-1:0] ar_word;

	function automatic logic in_range(input logic [axi_pkg::addr_w-1:0] word);
		return word < axi_pkg::addr_w'(DEPTH);
	endfunction

	assign aw_word = aw.addr >> off_w;
	assign ar_word = ar.addr >> off_w;

	assign aw_ready = (wr_state == soc_pkg::S_IDLE);
	assign w_ready  = (wr_state == soc_pkg::S_WDATA);
	assign b_valid  = (wr_state == soc_pkg::S_WRESP);
	assign b.id     = wr_id;
	assign b.resp   = wr_err ? axi_pkg::SLVERR : axi_pkg::OKAY;

	assign aw_fire = aw_valid & aw_ready;
	assign w_fire  = w_valid & w_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_state <= soc_pkg::S_IDLE;
		end else begin
			case (wr_state)
				soc_pkg::S_IDLE:  if (aw_fire) wr_state <= soc_pkg::S_WDATA;
				soc_pkg::S_WDATA: if (w_fire && wr_left == 8'd0) wr_state <= soc_pkg::S_WRESP;
				soc_pkg::S_WRESP: if (b_ready) wr_state <= soc_pkg::S_IDLE;
				default:          wr_state <= soc_pkg::S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			wr_addr  <= aw_word;
			wr_left  <= aw.len;
			wr_id    <= aw.id;
			wr_fixed <= (aw.burst == axi_pkg::FIXED);
			wr_err   <= 1'b0;
		end else if (w_fire) begin
			// error sticks for the rest of the burst
			wr_err  <= wr_err | !in_range(wr_addr);
			wr_left <= wr_left - 8'd1;
			if (!wr_fixed) begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	// byte lanes, out-of-range beats dropped
	always_ff @(posedge clk) begin
		if (w_fire && in_range(wr_addr)) begin
			for (int i = 0; i < axi_pkg::strb_w; i++) begin
				if (w.strb[i]) begin
					mem[wr_addr[idx_w-1:0]][8*i +: 8] <= w.data[8*i +: 8];
				end
			end
		end
	end

	// read engine
	assign ar_ready = !rd_active;
	assign r_valid  = rd_active;
	assign r_last   = (rd_left == 8'd0);
	assign ar_fire  = ar_valid & ar_ready;
	assign r_fire   = r_valid & r_ready;

	assign rd_next = rd_fixed ? rd_addr : rd_addr + 1'b1;
	assign rd_src  = ar_fire ? ar_word : rd_next;
	assign rd_word = in_range(rd_src) ? mem[rd_src[idx_w-1:0]] : '0;

	always_comb begin
		r.id   = rd_id;
		r.data = rd_data;
		r.resp = rd_err ? axi_pkg::SLVERR : axi_pkg::OKAY;
		r.last = r_last;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_active <= 1'b0;
		end else if (ar_fire) begin
			rd_active <= 1'b1;
		end else if (r_fire && r_last) begin
			rd_active <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rd_addr  <= ar_word;
			rd_left  <= ar.len;
			rd_id    <= ar.id;
			rd_fixed <= (ar.burst == axi_pkg::FIXED);
			// last word of the burst decides the response
			rd_err   <= !in_range((ar.burst == axi_pkg::FIXED) ? ar_word : ar_word + ar.len);
			rd_data  <= rd_word;
		end else if (r_fire && !r_last) begin
			rd_addr <= rd_next;
			rd_left <= rd_left - 8'd1;
			rd_data <= rd_word;
		end
	end

	a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
		aw_fire |-> (aw.burst != axi_pkg::WRAP));

endmodule

/* hdl/axi_interconnect.sv */
// two-master AXI interconnect onto a single slave port
// data master reads and writes while the fetch master only reads
// one write and one read in flight with mem winning read ties
module axi_interconnect (
	input  logic             clk,
	input  logic             rst_n,

	// data master
	input  axi_pkg::axi_ax_t mem_aw,
	input  logic             mem_aw_valid,
	output logic             mem_aw_ready,
	input  axi_pkg::axi_w_t  mem_w,
	input  logic             mem_w_valid,
	output logic             mem_w_ready,
	output axi_pkg::axi_b_t  mem_b,
	output logic             mem_b_valid,
	input  logic             mem_b_ready,
	input  axi_pkg::axi_ax_t mem_ar,
	input  logic             mem_ar_valid,
	output logic             mem_ar_ready,
	output axi_pkg::axi_r_t  mem_r,
	output logic             mem_r_valid,
	input  logic             mem_r_ready,

	// fetch master, read only
	input  axi_pkg::axi_ax_t if_ar,
	input  logic             if_ar_valid,
	output logic             if_ar_ready,
	output axi_pkg::axi_r_t  if_r,
	output logic             if_r_valid,
	input  logic             if_r_ready,

	// slave port
	output axi_pkg::axi_ax_t axi_aw,
	output logic             axi_aw_valid,
	input  logic             axi_aw_ready,
	output axi_pkg::axi_w_t  axi_w,
	output logic             axi_w_valid,
	input  logic             axi_w_ready,
	input  axi_pkg::axi_b_t  axi_b,
	input  logic             axi_b_valid,
	output logic             axi_b_ready,
	output axi_pkg::axi_ax_t axi_ar,
	output logic             axi_ar_valid,
	input  logic             axi_ar_ready,
	input  axi_pkg::axi_r_t  axi_r,
	input  logic             axi_r_valid,
	output logic             axi_r_ready
);

	soc_pkg::wr_state_e wr_state;
	soc_pkg::rd_state_e rd_state;
	soc_pkg::rd_owner_e rd_owner;
	soc_pkg::rd_owner_e ar_sel;

	logic wr_idle;
	logic rd_idle;
	logic own_mem;

	assign wr_idle = (wr_state == soc_pkg::WR_IDLE);
	assign rd_idle = (rd_state == soc_pkg::RD_IDLE);
	assign own_mem = (rd_owner == soc_pkg::OWN_MEM);

	// only the data master writes
	assign axi_aw       = mem_aw;
	assign axi_aw_valid = wr_idle & mem_aw_valid;
	assign mem_aw_ready = wr_idle & axi_aw_ready;

	assign axi_w        = mem_w;
	assign axi_w_valid  = !wr_idle & mem_w_valid;
	assign mem_w_ready  = !wr_idle & axi_w_ready;

	assign mem_b        = axi_b;
	assign mem_b_valid  = !wr_idle & axi_b_valid;
	assign axi_b_ready  = !wr_idle & mem_b_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_state <= soc_pkg::WR_IDLE;
		end else if (wr_idle) begin
			if (axi_aw_valid && axi_aw_ready) begin
				wr_state <= soc_pkg::WR_BUSY;
			end
		end else if (axi_b_valid && axi_b_ready) begin
			wr_state <= soc_pkg::WR_IDLE;
		end
	end

	// read arbitration with mem priority
	assign ar_sel       = mem_ar_valid ? soc_pkg::OWN_MEM : soc_pkg::OWN_IF;
	assign axi_ar       = (ar_sel == soc_pkg::OWN_MEM) ? mem_ar : if_ar;
	assign axi_ar_valid = rd_idle & (mem_ar_valid | if_ar_valid);
	assign mem_ar_ready = rd_idle & (ar_sel == soc_pkg::OWN_MEM) & axi_ar_ready;
	assign if_ar_ready  = rd_idle & (ar_sel == soc_pkg::OWN_IF) & axi_ar_ready;

	// R beats steered by the registered owner
	assign mem_r       = axi_r;
	assign if_r        = axi_r;
	assign mem_r_valid = !rd_idle & own_mem & axi_r_valid;
	assign if_r_valid  = !rd_idle & !own_mem & axi_r_valid;
	assign axi_r_ready = !rd_idle & (own_mem ? mem_r_ready : if_r_ready);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_state <= soc_pkg::RD_IDLE;
			rd_owner <= soc_pkg::OWN_MEM;
		end else if (rd_idle) begin
			if (axi_ar_valid && axi_ar_ready) begin
				rd_state <= soc_pkg::RD_BUSY;
				rd_owner <= ar_sel;
			end
		end else if (axi_r_valid && axi_r_ready && axi_r.last) begin
			rd_state <= soc_pkg::RD_IDLE;
		end
	end

	// slave answers a write only while one is open here
	a_b_in_write: assert property (@(posedge clk) disable iff (!rst_n)
		axi_b_valid |-> (wr_state == soc_pkg::WR_BUSY));

	// every R beat from the slave has a recorded owner
	a_r_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
		axi_r_valid |-> (rd_state == soc_pkg::RD_BUSY));

endmodule

/* hdl/soc_pkg.sv */
// interconnect busy states and read owner
// write-side states of the SRAM slave
package soc_pkg;

	typedef enum logic {
		WR_IDLE = 1'b0,
		WR_BUSY = 1'b1
	} wr_state_e;

	typedef enum logic {
		RD_IDLE = 1'b0,
		RD_BUSY = 1'b1
	} rd_state_e;

	typedef enum logic {
		OWN_MEM = 1'b0,
		OWN_IF  = 1'b1
	} rd_owner_e;

	typedef enum logic [1:0] {
		S_IDLE  = 2'b00,
		S_WDATA = 2'b01,
		S_WRESP = 2'b10
	} sram_state_e;

endpackage

/* hdl/axi_pkg.sv */
// AXI bus widths shared by masters, interconnect and slave
// channel payload structs for AW/AR, W, B and R
// burst type and response code enums
package axi_pkg;

	parameter int addr_w = 32;
	parameter int data_w = 64;
	parameter int id_w   = 4;
	parameter int strb_w = 8;

	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10
	} axi_burst_e;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	// shared by AW and AR
	typedef struct packed {
		logic [id_w-1:0]   id;
		logic [addr_w-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		axi_burst_e        burst;
	} axi_ax_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [strb_w-1:0] strb;
		logic              last;
	} axi_w_t;

	typedef struct packed {
		logic [id_w-1:0] id;
		axi_resp_e       resp;
	} axi_b_t;

	typedef struct packed {
		logic [id_w-1:0]   id;
		logic [data_w-1:0] data;
		axi_resp_e         resp;
		logic              last;
	} axi_r_t;

endpackage
